//--- hw/dn_decision_collector.sv
`timescale 1ns/100ps

module dn_decision_collector (
	input logic read_clk,
	input logic reset,
	input logic load_q,
	input logic [dn_pkg::DECISION_WIDTH-1:0] lane_decisions,
	output logic [dn_pkg::DECISION_WIDTH-1:0] decisions,
	output logic decisions_parity,
	output logic decisions_valid
);

	// Strobe delay matching the lane pipeline
	logic [dn_pkg::LANE_LATENCY-1:0] load_dly;
	logic collect;

	always_ff @(posedge read_clk) begin
		if (reset) begin
			load_dly <= '0;
		end else begin
			load_dly <= {load_dly[dn_pkg::LANE_LATENCY-2:0], load_q};
		end
	end

	assign collect = load_dly[dn_pkg::LANE_LATENCY-1];

	////////////////////
	// Decision word and even parity
	always_ff @(posedge read_clk) begin
		if (reset) begin
			decisions <= '0;
			decisions_parity <= 1'b0;
			decisions_valid <= 1'b0;
		end else begin
			decisions_valid <= collect;
			if (collect) begin
				decisions <= lane_decisions;
				decisions_parity <= ^lane_decisions;
			end
		end
	end

	// Collected word must come from written table entries
	a_decisions_known: assert property (
		@(posedge read_clk) disable iff (reset)
		collect |-> !$isunknown(lane_decisions)
	);

endmodule

//--- hw/dn_lut_bank.sv
`timescale 1ns/100ps

module dn_lut_bank (
	input logic read_clk,
	input logic we,
	input logic write_addr_offset,
	input logic lut_in_bank0,
	input logic lut_in_bank1,
	input dn_pkg::page_addr_t page_write_addr,
	input logic bank_a,
	input logic bank_b,
	input logic offset_a,
	input logic offset_b,
	input dn_pkg::page_addr_t page_a,
	input dn_pkg::page_addr_t page_b,
	output logic data_a,
	output logic data_b
);

	// Entry index is the offset bit above the page
	logic bank0_mem [dn_pkg::LUT_DEPTH];
	logic bank1_mem [dn_pkg::LUT_DEPTH];

	logic [dn_pkg::LUT_ADDR_WIDTH-1:0] write_index;
	logic [dn_pkg::LUT_ADDR_WIDTH-1:0] index_a, index_b;

	assign write_index = {write_addr_offset, page_write_addr};
	assign index_a = {offset_a, page_a};
	assign index_b = {offset_b, page_b};

	// Both banks load the same entry together
	always_ff @(posedge read_clk) begin
		if (we) begin
			bank0_mem[write_index] <= lut_in_bank0;
			bank1_mem[write_index] <= lut_in_bank1;
		end
	end

	// Asynchronous reads
	assign data_a = bank_a ? bank1_mem[index_a] : bank0_mem[index_a];
	assign data_b = bank_b ? bank1_mem[index_b] : bank0_mem[index_b];

	a_write_addr_known: assert property (
		@(posedge read_clk) we |-> !$isunknown(page_write_addr)
	);

endmodule

//--- hw/dn_lut_lane.sv
`timescale 1ns/100ps

module dn_lut_lane (
	input logic read_clk,
	input logic reset,
	dn_msg_if.sink msg,
	input logic we,
	input logic write_addr_offset,
	input logic lut_in_bank0,
	input logic lut_in_bank1,
	input dn_pkg::page_addr_t page_write_addr,
	output logic t_c_a,
	output logic t_c_b
);

	// Symmetric fold, result is {msb, y0[2:0], y1[3:0]}
	function automatic logic [7:0] fold_pair(
		input dn_pkg::msg_t y0,
		input dn_pkg::msg_t y1,
		input logic transpose
	);
		logic [2:0] y0_low;
		logic msb;
		dn_pkg::msg_t y1_f;
		y0_low = y0[3] ? ~y0[2:0] : y0[2:0];
		msb = transpose ^ y0[3];
		y1_f = msb ? ~y1 : y1;
		return {msb, y0_low, y1_f};
	endfunction

	logic [7:0] fold_a, fold_b;

	assign fold_a = fold_pair(msg.y0_a, msg.y1_a, msg.transpose_a);
	assign fold_b = fold_pair(msg.y0_b, msg.y1_b, msg.transpose_b);

	////////////////////
	// Stage 0
	logic [2:0] y0_s0_a, y0_s0_b;
	dn_pkg::msg_t y1_s0_a, y1_s0_b;
	logic msb_s0_a, msb_s0_b;
	logic offset_s0;

	always_ff @(posedge read_clk) begin
		if (reset) begin
			y0_s0_a <= '0;
			y0_s0_b <= '0;
			y1_s0_a <= '0;
			y1_s0_b <= '0;
			msb_s0_a <= 1'b0;
			msb_s0_b <= 1'b0;
			offset_s0 <= 1'b0;
		end else begin
			{msb_s0_a, y0_s0_a, y1_s0_a} <= fold_a;
			{msb_s0_b, y0_s0_b, y1_s0_b} <= fold_b;
			offset_s0 <= msg.read_addr_offset;
		end
	end

	// Table address, folded y1 sign picks the bank
	dn_pkg::page_addr_t page_a, page_b;
	logic lut_a, lut_b;

	assign page_a = {y0_s0_a, y1_s0_a[2:0]};
	assign page_b = {y0_s0_b, y1_s0_b[2:0]};

	dn_lut_bank u_lut_bank (
		.read_clk          (read_clk),
		.we                (we),
		.write_addr_offset (write_addr_offset),
		.lut_in_bank0      (lut_in_bank0),
		.lut_in_bank1      (lut_in_bank1),
		.page_write_addr   (page_write_addr),
		.bank_a            (y1_s0_a[3]),
		.bank_b            (y1_s0_b[3]),
		.offset_a          (offset_s0),
		.offset_b          (offset_s0),
		.page_a            (page_a),
		.page_b            (page_b),
		.data_a            (lut_a),
		.data_b            (lut_b)
	);

	////////////////////
	// Stage 1
	logic lut_s1_a, lut_s1_b;
	logic msb_s1_a, msb_s1_b;

	always_ff @(posedge read_clk) begin
		if (reset) begin
			lut_s1_a <= 1'b0;
			lut_s1_b <= 1'b0;
			msb_s1_a <= 1'b0;
			msb_s1_b <= 1'b0;
		end else begin
			lut_s1_a <= lut_a;
			lut_s1_b <= lut_b;
			msb_s1_a <= msb_s0_a;
			msb_s1_b <= msb_s0_b;
		end
	end

	// Hard decision restores the folded sign
	assign t_c_a = lut_s1_a ^ msb_s1_a;
	assign t_c_b = lut_s1_b ^ msb_s1_b;

endmodule

//--- hw/dn_msg_distributor.sv
`timescale 1ns/100ps

module dn_msg_distributor (
	input logic read_clk,
	input logic reset,
	input logic load,
	input logic [dn_pkg::DECISION_WIDTH*dn_pkg::MSG_WIDTH-1:0] msg_y0,
	input logic [dn_pkg::DECISION_WIDTH*dn_pkg::MSG_WIDTH-1:0] msg_y1,
	input logic [dn_pkg::DECISION_WIDTH-1:0] transpose_en,
	input logic read_addr_offset,
	dn_msg_if.source lanes [dn_pkg::LANE_COUNT],
	output logic load_q
);

	localparam int FLAT_WIDTH = dn_pkg::DECISION_WIDTH * dn_pkg::MSG_WIDTH;

	logic [FLAT_WIDTH-1:0] y0_hold, y1_hold;
	logic [dn_pkg::DECISION_WIDTH-1:0] transpose_hold;
	logic offset_hold;
	logic load_d;

	logic [FLAT_WIDTH-1:0] y0_out, y1_out;
	logic [dn_pkg::DECISION_WIDTH-1:0] transpose_out;
	logic offset_out;

	// Capture on load, hold otherwise
	always_ff @(posedge read_clk) begin
		if (reset) begin
			y0_hold <= '0;
			y1_hold <= '0;
			transpose_hold <= '0;
			offset_hold <= 1'b0;
			load_d <= 1'b0;
		end else begin
			load_d <= load;
			if (load) begin
				y0_hold <= msg_y0;
				y1_hold <= msg_y1;
				transpose_hold <= transpose_en;
				offset_hold <= read_addr_offset;
			end
		end
	end

	// Output stage, strobe follows the data it announces
	always_ff @(posedge read_clk) begin
		if (reset) begin
			y0_out <= '0;
			y1_out <= '0;
			transpose_out <= '0;
			offset_out <= 1'b0;
			load_q <= 1'b0;
		end else begin
			y0_out <= y0_hold;
			y1_out <= y1_hold;
			transpose_out <= transpose_hold;
			offset_out <= offset_hold;
			load_q <= load_d;
		end
	end

	////////////////////
	// Slice per lane, port A at the even decision index
	for (genvar g = 0; g < dn_pkg::LANE_COUNT; g++) begin : g_lane
		localparam int IDX_A = g * dn_pkg::PORTS_PER_LANE;
		localparam int IDX_B = IDX_A + 1;

		assign lanes[g].y0_a = y0_out[IDX_A*dn_pkg::MSG_WIDTH +: dn_pkg::MSG_WIDTH];
		assign lanes[g].y1_a = y1_out[IDX_A*dn_pkg::MSG_WIDTH +: dn_pkg::MSG_WIDTH];
		assign lanes[g].transpose_a = transpose_out[IDX_A];
		assign lanes[g].y0_b = y0_out[IDX_B*dn_pkg::MSG_WIDTH +: dn_pkg::MSG_WIDTH];
		assign lanes[g].y1_b = y1_out[IDX_B*dn_pkg::MSG_WIDTH +: dn_pkg::MSG_WIDTH];
		assign lanes[g].transpose_b = transpose_out[IDX_B];
		assign lanes[g].read_addr_offset = offset_out;
	end

	// A floating strobe would corrupt every lane at once
	a_load_known: assert property (
		@(posedge read_clk) !reset |-> !$isunknown(load)
	);

endmodule

//--- hw/dn_msg_if.sv
`timescale 1ns/100ps

// Message pairs and read controls for one decision-node lane
interface dn_msg_if;

	// Port A pair
	dn_pkg::msg_t y0_a;
	dn_pkg::msg_t y1_a;
	logic transpose_a;

	// Port B pair
	dn_pkg::msg_t y0_b;
	dn_pkg::msg_t y1_b;
	logic transpose_b;

	// Table half shared by both ports
	logic read_addr_offset;

	modport source (
		output y0_a, y1_a, transpose_a,
		output y0_b, y1_b, transpose_b,
		output read_addr_offset
	);

	modport sink (
		input y0_a, y1_a, transpose_a,
		input y0_b, y1_b, transpose_b,
		input read_addr_offset
	);

endinterface

//--- hw/dn_pkg.sv
package dn_pkg;

	////////////////////
	// Array geometry

	// Decision-node lanes and read ports per lane
	localparam int LANE_COUNT = 4;
	localparam int PORTS_PER_LANE = 2;

	// One hard decision per read port
	localparam int DECISION_WIDTH = LANE_COUNT * PORTS_PER_LANE;

	////////////////////
	// Message and table sizes

	// Incoming message, bit 3 is the sign
	localparam int MSG_WIDTH = 4;

	// Page address inside one table bank
	localparam int PAGE_ADDR_WIDTH = 6;

	// Offset bit plus page address selects one table entry
	localparam int LUT_ADDR_WIDTH = PAGE_ADDR_WIDTH + 1;
	localparam int LUT_DEPTH = 1 << LUT_ADDR_WIDTH;

	// Register stages between an interface change and a valid t_c
	localparam int LANE_LATENCY = 2;

	typedef logic [MSG_WIDTH-1:0] msg_t;
	typedef logic [PAGE_ADDR_WIDTH-1:0] page_addr_t;

endpackage

//--- hw/dn_top.sv
`timescale 1ns/100ps

module dn_top (
	input logic read_clk,
	input logic reset,
	input logic load,
	input logic read_addr_offset,
	input logic we,
	input logic write_addr_offset,
	input logic lut_in_bank0,
	input logic lut_in_bank1,
	input logic [dn_pkg::DECISION_WIDTH*dn_pkg::MSG_WIDTH-1:0] msg_y0,
	input logic [dn_pkg::DECISION_WIDTH*dn_pkg::MSG_WIDTH-1:0] msg_y1,
	input logic [dn_pkg::DECISION_WIDTH-1:0] transpose_en,
	input dn_pkg::page_addr_t page_write_addr,
	output logic [dn_pkg::DECISION_WIDTH-1:0] decisions,
	output logic decisions_parity,
	output logic decisions_valid
);

	dn_msg_if lane_msg [dn_pkg::LANE_COUNT] ();

	logic load_q;
	logic [dn_pkg::DECISION_WIDTH-1:0] lane_decisions;

	dn_msg_distributor u_distributor (
		.read_clk         (read_clk),
		.reset            (reset),
		.load             (load),
		.msg_y0           (msg_y0),
		.msg_y1           (msg_y1),
		.transpose_en     (transpose_en),
		.read_addr_offset (read_addr_offset),
		.lanes            (lane_msg),
		.load_q           (load_q)
	);

	////////////////////
	// Lanes share the table write port
	for (genvar g = 0; g < dn_pkg::LANE_COUNT; g++) begin : g_lane
		dn_lut_lane u_lane (
			.read_clk          (read_clk),
			.reset             (reset),
			.msg               (lane_msg[g]),
			.we                (we),
			.write_addr_offset (write_addr_offset),
			.lut_in_bank0      (lut_in_bank0),
			.lut_in_bank1      (lut_in_bank1),
			.page_write_addr   (page_write_addr),
			.t_c_a             (lane_decisions[g*dn_pkg::PORTS_PER_LANE]),
			.t_c_b             (lane_decisions[g*dn_pkg::PORTS_PER_LANE+1])
		);
	end

	dn_decision_collector u_collector (
		.read_clk         (read_clk),
		.reset            (reset),
		.load_q           (load_q),
		.lane_decisions   (lane_decisions),
		.decisions        (decisions),
		.decisions_parity (decisions_parity),
		.decisions_valid  (decisions_valid)
	);

endmodule

//--- list.f
hw/dn_pkg.sv
hw/dn_msg_if.sv
hw/dn_msg_distributor.sv
hw/dn_lut_bank.sv
hw/dn_lut_lane.sv
hw/dn_decision_collector.sv
hw/dn_top.sv
test/tb_dn_top.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the decision-node testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 \
	--top-module tb_dn_top -f list.f \
	--Mdir obj_dir -o sim_dn_top
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/sim_dn_top > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if grep -q "^Everything OK$" "$LOG"; then
	exit 0
fi
exit 1

//--- test/tb_dn_top.sv
`timescale 1ns/100ps

module tb_dn_top;

	localparam int DW = dn_pkg::DECISION_WIDTH;
	localparam int MW = dn_pkg::MSG_WIDTH;

	logic read_clk, reset, load, read_addr_offset;
	logic we, write_addr_offset, lut_in_bank0, lut_in_bank1;
	logic [DW*MW-1:0] msg_y0, msg_y1;
	logic [DW-1:0] transpose_en;
	dn_pkg::page_addr_t page_write_addr;
	logic [DW-1:0] decisions;
	logic decisions_parity, decisions_valid;

	// Model of one lane's table, index is {bank, offset, page}
	logic shadow [256];
	integer seed;
	int errors;
	int checks;

	dn_top u_dn_top (
		.read_clk         (read_clk),
		.reset            (reset),
		.load             (load),
		.read_addr_offset (read_addr_offset),
		.we               (we),
		.write_addr_offset(write_addr_offset),
		.lut_in_bank0     (lut_in_bank0),
		.lut_in_bank1     (lut_in_bank1),
		.msg_y0           (msg_y0),
		.msg_y1           (msg_y1),
		.transpose_en     (transpose_en),
		.page_write_addr  (page_write_addr),
		.decisions        (decisions),
		.decisions_parity (decisions_parity),
		.decisions_valid  (decisions_valid)
	);

	initial begin
		read_clk = 1'b0;
		forever #10 read_clk = ~read_clk;
	end

	////////////////////
	// Reference model

	// Fold by sign, look up, then restore the sign
	function automatic logic fold_decision(input dn_pkg::msg_t y0, input dn_pkg::msg_t y1,
		input logic tr, input logic off);
		logic [2:0] y0_low;
		logic sign;
		dn_pkg::msg_t y1_f;
		sign = tr ^ y0[3];
		y0_low = y0[2:0] ^ {3{y0[3]}};
		y1_f = y1 ^ {4{sign}};
		return shadow[{y1_f[3], off, y0_low, y1_f[2:0]}] ^ sign;
	endfunction

	function automatic logic [DW-1:0] expected_word(input logic [DW*MW-1:0] y0,
		input logic [DW*MW-1:0] y1, input logic [DW-1:0] tr, input logic off);
		logic [DW-1:0] word;
		for (int i = 0; i < DW; i++) begin
			word[i] = fold_decision(y0[i*MW +: MW], y1[i*MW +: MW], tr[i], off);
		end
		return word;
	endfunction

	////////////////////
	// Drivers and checks

	task automatic check_value(input string name, input logic [DW-1:0] exp,
		input logic [DW-1:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("[FAIL] %0t %s expected %h got %h", $time, name, exp, act);
		end
	endtask

	task automatic check_word(input logic [DW-1:0] exp);
		check_value("decisions", exp, decisions);
		// Even parity over the expected word
		check_value("decisions_parity", DW'(^exp), DW'(decisions_parity));
	endtask

	task automatic write_entry(input logic off, input dn_pkg::page_addr_t page,
		input logic b0, input logic b1);
		we = 1'b1;
		write_addr_offset = off;
		page_write_addr = page;
		lut_in_bank0 = b0;
		lut_in_bank1 = b1;
		shadow[{1'b0, off, page}] = b0;
		shadow[{1'b1, off, page}] = b1;
		@(posedge read_clk);
		#2;
		we = 1'b0;
	endtask

	// Both banks of one offset half, pattern mixes in the full address
	task automatic fill_table(input logic off, input logic [7:0] salt);
		logic [7:0] h;
		@(posedge read_clk);
		#2;
		for (int p = 0; p < 64; p++) begin
			h = {1'b0, off, dn_pkg::page_addr_t'(p)} * 8'd29 + salt;
			write_entry(off, dn_pkg::page_addr_t'(p), h[3] ^ h[6], h[2] ^ h[5] ^ h[0]);
		end
	endtask

	task automatic rand_msgs(output logic [DW*MW-1:0] y0, output logic [DW*MW-1:0] y1,
		output logic [DW-1:0] tr);
		y0 = $random(seed);
		y1 = $random(seed);
		tr = DW'($random(seed));
	endtask

	task automatic drive_load(input logic [DW*MW-1:0] y0, input logic [DW*MW-1:0] y1,
		input logic [DW-1:0] tr, input logic off);
		msg_y0 = y0;
		msg_y1 = y1;
		transpose_en = tr;
		read_addr_offset = off;
		load = 1'b1;
	endtask

	// Edges counted until decisions_valid, bounded at 20
	task automatic wait_valid(output int edges);
		edges = 0;
		do begin
			@(posedge read_clk);
			#1;
			edges++;
		end while (!decisions_valid && edges < 20);
		if (!decisions_valid) begin
			errors++;
			$display("Timeout: decisions_valid did not rise within 20 cycles at %0t", $time);
		end
	endtask

	task automatic run_load(input logic [DW*MW-1:0] y0, input logic [DW*MW-1:0] y1,
		input logic [DW-1:0] tr, input logic off);
		logic [DW-1:0] exp;
		int edges;
		exp = expected_word(y0, y1, tr, off);
		@(posedge read_clk);
		#2;
		drive_load(y0, y1, tr, off);
		@(posedge read_clk);
		#2;
		load = 1'b0;
		wait_valid(edges);
		if (decisions_valid) begin
			check_value("decisions_valid latency", DW'(4), DW'(edges));
			check_word(exp);
		end
	endtask

	////////////////////
	// Directed tests

	task automatic test_reset_state();
		repeat (6) begin
			@(posedge read_clk);
			#1;
			check_value("decisions_valid", '0, DW'(decisions_valid));
			check_value("decisions", '0, decisions);
			check_value("decisions_parity", '0, DW'(decisions_parity));
		end
	endtask

	task automatic test_plain_read();
		logic [DW*MW-1:0] y0, y1;
		logic [DW-1:0] tr;
		fill_table(1'b0, 8'h5a);
		fill_table(1'b1, 8'hc3);
		repeat (3) begin
			rand_msgs(y0, y1, tr);
			run_load(y0 & {DW{4'h7}}, y1, '0, 1'b0);
		end
	endtask

	task automatic test_folding();
		logic [DW*MW-1:0] y0, y1;
		logic [DW-1:0] tr;
		for (int k = 0; k < 4; k++) begin
			rand_msgs(y0, y1, tr);
			if (k == 0)
				tr = '0;
			else if (k == 1)
				tr = '1;
			run_load(y0 | {DW{4'h8}}, y1, tr, k[0]);
		end
	endtask

	task automatic test_offset();
		logic [DW*MW-1:0] y0, y1;
		logic [DW-1:0] tr;
		fill_table(1'b1, 8'h3c);
		repeat (2) begin
			rand_msgs(y0, y1, tr);
			run_load(y0, y1, tr, 1'b0);
			run_load(y0, y1, tr, 1'b1);
		end
	endtask

	task automatic test_back_to_back();
		logic [DW*MW-1:0] y0, y1;
		logic [DW-1:0] tr;
		logic [DW-1:0] exp [4];
		int rnd;
		int edges;
		for (int k = 0; k < 4; k++) begin
			rand_msgs(y0, y1, tr);
			rnd = $random(seed);
			exp[k] = expected_word(y0, y1, tr, rnd[0]);
			@(posedge read_clk);
			#2;
			drive_load(y0, y1, tr, rnd[0]);
		end
		@(posedge read_clk);
		#2;
		load = 1'b0;
		// First word one edge after the last load edge
		wait_valid(edges);
		if (decisions_valid) begin
			check_value("decisions_valid latency", DW'(1), DW'(edges));
			check_word(exp[0]);
			for (int k = 1; k < 4; k++) begin
				@(posedge read_clk);
				#1;
				check_value("decisions_valid", DW'(1), DW'(decisions_valid));
				check_word(exp[k]);
			end
			@(posedge read_clk);
			#1;
			check_value("decisions_valid", '0, DW'(decisions_valid));
		end
	endtask

	task automatic test_parity();
		logic [DW*MW-1:0] y0, y1;
		logic [DW-1:0] tr;
		int rnd;
		repeat (4) begin
			rand_msgs(y0, y1, tr);
			rnd = $random(seed);
			run_load(y0, y1, tr, rnd[0]);
		end
	endtask

	initial begin
		seed = 14;
		errors = 0;
		checks = 0;
		reset = 1'b1;
		load = 1'b0;
		read_addr_offset = 1'b0;
		we = 1'b0;
		write_addr_offset = 1'b0;
		lut_in_bank0 = 1'b0;
		lut_in_bank1 = 1'b0;
		msg_y0 = '0;
		msg_y1 = '0;
		transpose_en = '0;
		page_write_addr = '0;
		repeat (2) @(posedge read_clk);
		#2;
		reset = 1'b0;

		test_reset_state();
		test_plain_read();
		test_folding();
		test_offset();
		test_back_to_back();
		test_parity();

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule
